// File: hdl/mmu_addr_pkg.sv
`default_nettype none

`include "mmu_settings.svh"

package mmu_addr_pkg;

    // Page number, physical or virtual
    typedef logic [`MMU_PAGE_W-1:0] page_t;

    // Page map word
    typedef struct packed {
        page_t                               page;  // Physical page, upper half
        logic [`MMU_MAP_W-`MMU_PAGE_W-1:0]   attr;  // Lower half, kept for read-back
    } map_entry_t;

    // Translated address as seen by the memory side
    typedef struct packed {
        page_t                  page;               // Physical page
        logic [`MMU_OFS_W-1:0]  ofs;                // Word within page
    } physad_t;

    // Number of pages in every per-page memory
    localparam int PAGES = 1 << `MMU_PAGE_W;

endpackage

`default_nettype wire

// File: hdl/mmu_ctrl_pkg.sv
`default_nettype none

package mmu_ctrl_pkg;

    // Arbiter opcode, only the write operations are named
    typedef enum logic [3:0] {
        ARB_CCWR  = 4'd2,           // Instruction cache write
        ARB_DCWR  = 4'd4,           // Operand cache write
        ARB_DWR   = 4'd10,          // Result write
        ARB_RDMWR = 4'd11,          // Read-modify-write
        ARB_BTRWR = 4'd12           // Block transfer write
    } arb_op_t;

    // Mode register layout, bit 31 first
    typedef struct packed {
        logic [1:0] rr_unused;      // 31:30 Spare
        logic       flag_jump;      // 29 Jump instruction flag
        logic       rcb;            // 28 Right command flag
        logic       cb;             // 27 Address changed by index
        logic       no_paging;      // 26 Paging disable
        logic       no_procnm;      // 25 No process number check
        logic       flag_negaddr;   // 24 Negative address mode
        logic       no_rprot;       // 23 No read protection
        logic       no_wprot;       // 22 No write protection
        logic       intstp;         // 21 Stop on interrupt
        logic       single_step;    // 20 Single step mode
        logic       cemlrg;         // 19 Reserved emulation bit
        logic       no_wtag;        // 18 No tag check on write
        logic       no_intr;        // 17 External interrupts masked
        logic       no_progtag;     // 16 No program tag interpretation
        logic       no_badacc;      // 15 No foreign accumulator trap
        logic       no_rtag;        // 14 No tag check on operand read
        logic       no_badop;       // 13 No foreign operand trap
        logic       drg;            // 12 Dispatcher mode
        logic       ovrftb;         // 11 No stack overflow check
        logic       bnb;            // 10 No BESM-6 range check
        logic       flag_z;         // 9 Zero
        logic       flag_n;         // 8 Negative
        logic       flag_c;         // 7 Carry
        logic       flag_v;         // 6 Overflow
        logic       ovrib;          // 5 Overflow interrupt blocked
        logic [2:0] grp;            // 4:2 Condition group
        logic       rndb;           // 1 Rounding blocked
        logic       normb;          // 0 Normalization blocked
    } rr_fields_t;

    // Software sees a raw word, the unit reads single fields
    typedef union packed {
        logic [31:0] raw;
        rr_fields_t  fields;
    } rr_word_u;

endpackage

`default_nettype wire

// File: hdl/mmu_if.sv
`default_nettype none
`timescale 1ns/1ns

`include "mmu_settings.svh"

// ----------------------------------------------------------------------
// Translation setup, mode registers to translator
// ----------------------------------------------------------------------
interface xlat_cfg_if;
    import mmu_ctrl_pkg::*;

    logic [`MMU_ADDR_W-1:0] ureg;       // Effective address
    logic                   no_paging;  // Map bypass
    logic                   besm6;      // Short virtual page
    arb_op_t                arb_op;     // Opcode seen by the translator

    modport src (output ureg, no_paging, besm6, arb_op);
    modport dst (input  ureg, no_paging, besm6, arb_op);

endinterface

// ----------------------------------------------------------------------
// Page selection and access marks, translator to status memories
// ----------------------------------------------------------------------
interface page_if;
    import mmu_addr_pkg::*;

    page_t pg_index;                    // Physical page register
    page_t xlat_page;                   // Current translation result
    logic  touch;                       // Mark xlat_page used
    logic  touch_dirty;                 // Mark xlat_page dirty too

    modport src (output pg_index, xlat_page, touch, touch_dirty);
    modport dst (input  pg_index, xlat_page, touch, touch_dirty);

endinterface

`default_nettype wire

// File: hdl/mmu_settings.svh
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Effective-address register and data word width
`define MMU_ADDR_W 32

// Physical and virtual page number width
`define MMU_PAGE_W 10

// In-page word offset
`define MMU_OFS_W 10

// Virtual page width in BESM-6 emulation mode
`define MMU_BESM_PAGE_W 5

// Page map entry width
`define MMU_MAP_W 20

`endif

// File: hdl/mmu_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "mmu_settings.svh"

module mmu_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_ureg_wr,     // Effective address write
    input  logic                     i_rr_wr,       // Mode register write
    input  logic                     i_set_besm6,   // Emulation on
    input  logic                     i_clr_besm6,   // Emulation off
    input  logic                     i_map_wr,      // Page map write
    input  logic                     i_physpg_wr,   // Physical page write
    input  logic                     i_arb_req,     // Bus request
    input  mmu_ctrl_pkg::arb_op_t    i_arb_op,      // Arbiter opcode
    input  logic                     i_access_wr,   // Used and dirty write
    input  logic                     i_reprio_wr,   // Reprioritize write
    input  logic                     i_fill_start,  // Reprioritize fill
    input  logic [`MMU_ADDR_W-1:0]   i_y,           // Data word
    input  logic [2:0]               i_d,           // Status bits to write
    output mmu_addr_pkg::physad_t    o_physad,      // Physical address
    output mmu_addr_pkg::map_entry_t o_map_rdata,   // Map read-back
    output logic [31:0]              o_rr,          // Mode register
    output logic [1:0]               o_access,      // Dirty, used
    output logic                     o_reprio,      // Reprioritize bit
    output logic                     o_fill_busy    // Fill running
);

    xlat_cfg_if u_cfg ();               // Mode to translator
    page_if     u_pg ();                // Translator to status

    // ------------------------------------------------------------------
    // Units
    // ------------------------------------------------------------------
    mode_regs u_mode_regs (
        .clk         (clk),
        .reset       (reset),
        .i_ureg_wr   (i_ureg_wr),
        .i_rr_wr     (i_rr_wr),
        .i_set_besm6 (i_set_besm6),
        .i_clr_besm6 (i_clr_besm6),
        .i_arb_req   (i_arb_req),
        .i_arb_op    (i_arb_op),
        .i_y         (i_y),
        .o_rr        (o_rr),
        .cfg         (u_cfg.src)
    );

    page_translate u_page_translate (
        .clk         (clk),
        .reset       (reset),
        .i_map_wr    (i_map_wr),
        .i_physpg_wr (i_physpg_wr),
        .i_arb_req   (i_arb_req),
        .i_y         (i_y),
        .o_physad    (o_physad),
        .o_map_rdata (o_map_rdata),
        .cfg         (u_cfg.dst),
        .pg          (u_pg.src)
    );

    page_status u_page_status (
        .clk          (clk),
        .reset        (reset),
        .i_access_wr  (i_access_wr),
        .i_reprio_wr  (i_reprio_wr),
        .i_fill_start (i_fill_start),
        .i_d          (i_d),
        .o_access     (o_access),
        .o_reprio     (o_reprio),
        .o_fill_busy  (o_fill_busy),
        .pg           (u_pg.dst)
    );

endmodule

`default_nettype wire

// File: hdl/mode_regs.sv
`default_nettype none
`timescale 1ns/1ns

`include "mmu_settings.svh"

module mode_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_ureg_wr,     // Load effective address
    input  logic                   i_rr_wr,       // Load mode register
    input  logic                   i_set_besm6,   // Enter emulation mode
    input  logic                   i_clr_besm6,   // Leave emulation mode
    input  logic                   i_arb_req,     // Bus request
    input  mmu_ctrl_pkg::arb_op_t  i_arb_op,      // Opcode of this request
    input  logic [`MMU_ADDR_W-1:0] i_y,           // Data word
    output logic [31:0]            o_rr,          // Mode register read-back
    xlat_cfg_if.src                cfg
);
    import mmu_ctrl_pkg::*;

    logic [`MMU_ADDR_W-1:0] ureg;                 // Effective-address register
    rr_word_u               rr;                   // Mode register
    logic                   besm6;                // Emulation flag
    arb_op_t                arb_op_q;             // Opcode of the last request

    // ------------------------------------------------------------------
    // Address and mode registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ureg   <= '0;
            rr.raw <= '0;
        end else begin
            if (i_ureg_wr)
                ureg <= i_y;                      // Whole word
            if (i_rr_wr)
                rr.raw <= i_y[31:0];              // Loaded raw
        end
    end

    // Emulation flag, set and clear strobes
    always_ff @(posedge clk) begin
        if (reset)
            besm6 <= 1'b0;                        // Native mode after reset
        else if (i_set_besm6)
            besm6 <= 1'b1;
        else if (i_clr_besm6)
            besm6 <= 1'b0;
    end

    // Opcode register, follows every request
    always_ff @(posedge clk) begin
        if (reset)
            arb_op_q <= arb_op_t'(4'd0);
        else if (i_arb_req)
            arb_op_q <= i_arb_op;
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign o_rr          = rr.raw;                // Read back as written
    assign cfg.ureg      = ureg;
    assign cfg.no_paging = rr.fields.no_paging;   // Bit 26
    assign cfg.besm6     = besm6;
    assign cfg.arb_op    = i_arb_req ? i_arb_op : arb_op_q;  // Current op bypasses

    // Set and clear come from one decoder and never coincide
    a_besm6_strobes: assert property (@(posedge clk) disable iff (reset)
        !(i_set_besm6 && i_clr_besm6))
        else $error("besm6 set and clear strobes high together");

endmodule

`default_nettype wire

// File: hdl/page_status.sv
`default_nettype none
`timescale 1ns/1ns

`include "mmu_settings.svh"

module page_status (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_access_wr,     // Software write of used and dirty
    input  logic       i_reprio_wr,     // Software write of reprioritize bit
    input  logic       i_fill_start,    // Start filling reprioritize bits
    input  logic [2:0] i_d,             // Dirty, used, reprio
    output logic [1:0] o_access,        // Dirty, used at pg_index
    output logic       o_reprio,        // Reprioritize bit at pg_index
    output logic       o_fill_busy,     // Fill in progress
    page_if.dst        pg
);
    import mmu_addr_pkg::*;

    localparam page_t LAST_PAGE = '1;   // Page 1023

    logic  used_mem   [PAGES];          // Page referenced
    logic  dirty_mem  [PAGES];          // Page modified
    logic  reprio_mem [PAGES];          // Reprioritize request
    logic  fill_busy;                   // Fill sequencer active
    page_t fill_cnt;                    // Next page to fill

    // ------------------------------------------------------------------
    // Used and dirty bits
    // ------------------------------------------------------------------
    // Software and a request may hit different pages in one cycle
    always_ff @(posedge clk) begin
        if (i_access_wr) begin
            used_mem[pg.pg_index]  <= i_d[1];
            dirty_mem[pg.pg_index] <= i_d[2];
        end
        if (pg.touch)
            used_mem[pg.xlat_page] <= 1'b1;     // Request marks used
        if (pg.touch_dirty)
            dirty_mem[pg.xlat_page] <= 1'b1;    // Write request marks dirty
    end

    assign o_access = {dirty_mem[pg.pg_index], used_mem[pg.pg_index]};

    // ------------------------------------------------------------------
    // Fill sequencer
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_busy <= 1'b0;
            fill_cnt  <= '0;
        end else if (fill_busy) begin
            if (fill_cnt == LAST_PAGE)
                fill_busy <= 1'b0;              // Last page written now
            else
                fill_cnt <= fill_cnt + 1'b1;
        end else if (i_fill_start) begin
            fill_busy <= 1'b1;
            fill_cnt  <= pg.pg_index;           // From current page upward
        end
    end

    // Reprioritize bits, fill locks out software
    always_ff @(posedge clk) begin
        if (fill_busy)
            reprio_mem[fill_cnt] <= 1'b1;
        else if (i_reprio_wr)
            reprio_mem[pg.pg_index] <= i_d[0];
    end

    assign o_reprio    = reprio_mem[pg.pg_index];
    assign o_fill_busy = fill_busy;

    // Counter only climbs while busy and stops at the top page
    a_fill_no_wrap: assert property (@(posedge clk) disable iff (reset)
        fill_busy |=> !fill_busy || fill_cnt > $past(fill_cnt))
        else $error("fill counter wrapped past last page");

endmodule

`default_nettype wire

// File: hdl/page_translate.sv
`default_nettype none
`timescale 1ns/1ns

`include "mmu_settings.svh"

module page_translate (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_map_wr,     // Write map at ureg page
    input  logic                     i_physpg_wr,  // Load physical page register
    input  logic                     i_arb_req,    // Bus request
    input  logic [`MMU_ADDR_W-1:0]   i_y,          // Data word
    output mmu_addr_pkg::physad_t    o_physad,     // Translated address
    output mmu_addr_pkg::map_entry_t o_map_rdata,  // Map read-back
    xlat_cfg_if.dst                  cfg,
    page_if.src                      pg
);
    import mmu_addr_pkg::*;
    import mmu_ctrl_pkg::*;

    map_entry_t map_mem [PAGES];                  // Page map memory
    page_t      map_idx;                          // Map index from ureg
    page_t      pg_virt;                          // Virtual page
    page_t      pg_xlat;                          // Translated page
    page_t      pg_index;                         // Physical page register
    logic       wr_op;                            // Opcode writes memory

    // ------------------------------------------------------------------
    // Page map
    // ------------------------------------------------------------------
    assign map_idx = cfg.ureg[`MMU_OFS_W +: `MMU_PAGE_W];   // ureg 19:10

    always_ff @(posedge clk) begin
        if (i_map_wr)
            map_mem[map_idx] <= i_y[`MMU_MAP_W-1:0];
    end

    assign o_map_rdata = map_mem[map_idx];        // Same index as writes

    // ------------------------------------------------------------------
    // Translation
    // ------------------------------------------------------------------
    // BESM-6 pages are 5 bits wide, upper bits forced to zero
    assign pg_virt = cfg.besm6
        ? page_t'(cfg.ureg[`MMU_OFS_W +: `MMU_BESM_PAGE_W])
        : map_idx;

    assign pg_xlat = cfg.no_paging ? pg_virt : map_mem[pg_virt].page;

    assign o_physad.page = pg_xlat;
    assign o_physad.ofs  = cfg.ureg[`MMU_OFS_W-1:0];  // Offset passes through

    // Physical page register, request wins over software
    always_ff @(posedge clk) begin
        if (reset)
            pg_index <= '0;
        else if (i_arb_req)
            pg_index <= pg_xlat;
        else if (i_physpg_wr)
            pg_index <= i_y[`MMU_OFS_W +: `MMU_PAGE_W];
    end

    // Write operations mark the page dirty
    always_comb begin
        case (cfg.arb_op)
            ARB_CCWR,
            ARB_DCWR,
            ARB_DWR,
            ARB_RDMWR,
            ARB_BTRWR: wr_op = 1'b1;
            default:   wr_op = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // Status side
    // ------------------------------------------------------------------
    assign pg.pg_index    = pg_index;
    assign pg.xlat_page   = pg_xlat;
    assign pg.touch       = i_arb_req;            // Every request marks used
    assign pg.touch_dirty = i_arb_req && wr_op;

    // A request must never mark a page from an unknown map entry
    a_physad_known: assert property (@(posedge clk) disable iff (reset)
        i_arb_req |-> !$isunknown(o_physad))
        else $error("o_physad unknown at a bus request");

endmodule

`default_nettype wire

// File: sim.f
+incdir+hdl
+incdir+sim
hdl/mmu_addr_pkg.sv
hdl/mmu_ctrl_pkg.sv
hdl/mmu_if.sv
hdl/mode_regs.sv
hdl/page_translate.sv
hdl/page_status.sv
hdl/mmu_top.sv
sim/tb_mmu.sv

// File: sim/mmu_model.svh
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

// ----------------------------------------------------------------------
// Reference state, one copy of every register and memory
// ----------------------------------------------------------------------
logic [`MMU_ADDR_W-1:0] m_ureg;                 // Effective address
logic [31:0]            m_rr;                   // Mode register word
logic                   m_besm6;                // Emulation flag
logic [`MMU_PAGE_W-1:0] m_pg;                   // Physical page register
logic                   m_fill_busy;
logic [`MMU_PAGE_W-1:0] m_fill_cnt;             // Next page to fill
logic [`MMU_MAP_W-1:0]  m_map    [PAGES];
logic                   m_used   [PAGES];
logic                   m_dirty  [PAGES];
logic                   m_reprio [PAGES];

// CCWR, DCWR, DWR, RDMWR, BTRWR
function automatic logic is_write_op(input logic [3:0] op);
    return op == 4'd2 || op == 4'd4 || op == 4'd10 || op == 4'd11 || op == 4'd12;
endfunction

// Page after translation, in the current mode
function automatic logic [`MMU_PAGE_W-1:0] predict_page();
    logic [`MMU_PAGE_W-1:0] vp;
    vp = m_besm6 ? {5'd0, m_ureg[14:10]} : m_ureg[19:10];   // 5 or 10 bit page
    if (m_rr[26])
        return vp;                              // Paging disabled
    return m_map[vp][19:10];
endfunction

function automatic logic [19:0] predict_physad();
    return {predict_page(), m_ureg[9:0]};
endfunction

// One rising edge with the inputs now on the pins
task automatic model_step();
    logic [`MMU_PAGE_W-1:0] xp;
    logic [`MMU_PAGE_W-1:0] pg_next;
    xp      = predict_page();                   // From state before the edge
    pg_next = arb_req ? xp : (physpg_wr ? y[19:10] : m_pg);
    if (map_wr)
        m_map[m_ureg[19:10]] = y[19:0];
    if (access_wr) begin
        m_used[m_pg]  = d[1];
        m_dirty[m_pg] = d[2];
    end
    if (arb_req) begin
        m_used[xp] = 1'b1;                      // Request wins on same page
        if (is_write_op(arb_op))
            m_dirty[xp] = 1'b1;
    end
    if (m_fill_busy === 1'b1)
        m_reprio[m_fill_cnt] = 1'b1;            // Software locked out
    else if (reprio_wr)
        m_reprio[m_pg] = d[0];
    if (reset) begin
        m_ureg      = '0;
        m_rr        = '0;
        m_besm6     = 1'b0;
        m_pg        = '0;
        m_fill_busy = 1'b0;
        m_fill_cnt  = '0;
    end else begin
        if (ureg_wr)
            m_ureg = y;
        if (rr_wr)
            m_rr = y;
        if (set_besm6)
            m_besm6 = 1'b1;
        else if (clr_besm6)
            m_besm6 = 1'b0;
        if (m_fill_busy) begin
            if (m_fill_cnt == '1)
                m_fill_busy = 1'b0;             // Page 1023 written
            else
                m_fill_cnt = m_fill_cnt + 1'b1;
        end else if (fill_start) begin
            m_fill_busy = 1'b1;
            m_fill_cnt  = m_pg;                 // Old page register
        end
        m_pg = pg_next;
    end
endtask

`endif

// File: sim/tb_mmu.sv
`default_nettype none
`timescale 1ns/1ns

`include "mmu_settings.svh"

module tb_mmu;
    import mmu_addr_pkg::*;
    import mmu_ctrl_pkg::*;

    localparam int          FILL_TIMEOUT = 1100;        // Longest fill is 1024
    localparam logic [31:0] SEED         = 32'hdb401740;

    logic clk, reset;
    logic ureg_wr, rr_wr, set_besm6, clr_besm6, map_wr, physpg_wr;
    logic arb_req, access_wr, reprio_wr, fill_start;
    arb_op_t arb_op;
    logic [31:0] y;
    logic [2:0]  d;
    physad_t     physad;
    map_entry_t  map_rdata;
    logic [31:0] rr;
    logic [1:0]  access;
    logic        reprio, fill_busy;

    logic [31:0] lfsr;
    logic [3:0]  op;
    logic        saved [PAGES];                         // Reprio bits before fill
    int          start, cycles, errors, timeouts;

    `include "mmu_model.svh"

    mmu_top uut (
        .clk(clk), .reset(reset),
        .i_ureg_wr(ureg_wr), .i_rr_wr(rr_wr),
        .i_set_besm6(set_besm6), .i_clr_besm6(clr_besm6),
        .i_map_wr(map_wr), .i_physpg_wr(physpg_wr),
        .i_arb_req(arb_req), .i_arb_op(arb_op),
        .i_access_wr(access_wr), .i_reprio_wr(reprio_wr), .i_fill_start(fill_start),
        .i_y(y), .i_d(d),
        .o_physad(physad), .o_map_rdata(map_rdata), .o_rr(rr),
        .o_access(access), .o_reprio(reprio), .o_fill_busy(fill_busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                          // 4 ns period
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic tick();
        @(posedge clk);
        model_step();                                   // Same inputs as the DUT
        #1;                                             // Drive point
    endtask

    task automatic clear_strobes();
        {ureg_wr, rr_wr, set_besm6, clr_besm6, map_wr, physpg_wr} = '0;
        {arb_req, access_wr, reprio_wr, fill_start} = '0;
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs();
        compare("o_physad", predict_physad(), physad);
        compare("o_map_rdata", m_map[m_ureg[19:10]], map_rdata);
        compare("o_rr", m_rr, rr);
        compare("o_access", {m_dirty[m_pg], m_used[m_pg]}, access);
        compare("o_reprio", m_reprio[m_pg], reprio);
        compare("o_fill_busy", m_fill_busy, fill_busy);
    endtask

    // 0 normal, 1 BESM-6, 2 paging off
    task automatic set_mode(input int mode);
        clear_strobes();
        rr_wr     = 1'b1;
        y         = (mode == 2) ? 32'h0400_0000 : 32'h0;   // Bit 26
        set_besm6 = (mode == 1);
        clr_besm6 = (mode != 1);
        tick();
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        lfsr = SEED;
        errors = 0;
        timeouts = 0;
        reset = 1'b1;
        clear_strobes();
        arb_op = arb_op_t'(4'd0);
        y = '0;
        d = '0;
        repeat (4) tick();
        reset = 1'b0;
        compare("o_rr", 32'h0, rr);
        compare("o_fill_busy", 32'h0, fill_busy);

        // Known contents in every memory
        for (int p = 0; p < PAGES; p++) begin
            clear_strobes();
            ureg_wr   = 1'b1;
            physpg_wr = 1'b1;
            y         = p << 10;
            tick();
            clear_strobes();
            map_wr    = 1'b1;
            access_wr = 1'b1;
            reprio_wr = 1'b1;
            y         = rand_bits(20);
            d         = 3'(rand_bits(3));
            tick();
        end
        check_outputs();

        // Mode register and map read-back
        for (int i = 0; i < 16; i++) begin
            clear_strobes();
            rr_wr = 1'b1;
            y     = rand_bits(32);
            tick();
            compare("o_rr", y, rr);
            clear_strobes();
            ureg_wr = 1'b1;
            y       = rand_bits(32);
            tick();
            clear_strobes();
            map_wr = 1'b1;
            y      = rand_bits(32);
            tick();
            compare("o_map_rdata", y[19:0], map_rdata);
            check_outputs();
        end

        // Translation in all three modes
        for (int mode = 0; mode < 3; mode++) begin
            set_mode(mode);
            for (int i = 0; i < 30; i++) begin
                clear_strobes();
                ureg_wr = 1'b1;
                y       = rand_bits(32);
                tick();
                check_outputs();
            end
        end

        // Requests, sometimes with a competing page write
        for (int i = 0; i < 40; i++) begin
            clear_strobes();
            ureg_wr   = 1'b1;
            rr_wr     = 1'(rand_bits(1));
            y         = rand_bits(32);
            op        = 4'(rand_bits(2));
            set_besm6 = (op == 4'd1);
            clr_besm6 = (op == 4'd2);
            tick();
            clear_strobes();
            arb_req   = 1'b1;
            op        = 4'(rand_bits(4));
            arb_op    = arb_op_t'(op);
            physpg_wr = 1'(rand_bits(1));
            y         = rand_bits(32);
            tick();
            check_outputs();
            compare("o_access.used", 1'b1, access[0]);
            if (is_write_op(op))
                compare("o_access.dirty", 1'b1, access[1]);
            clear_strobes();
            physpg_wr = 1'b1;
            y         = rand_bits(32);
            tick();
            check_outputs();
        end

        // Software writes of status bits
        for (int i = 0; i < 30; i++) begin
            clear_strobes();
            physpg_wr = 1'b1;
            y         = rand_bits(32);
            tick();
            clear_strobes();
            access_wr = 1'b1;
            reprio_wr = 1'b1;
            d         = 3'(rand_bits(3));
            tick();
            compare("o_access", d[2:1], access);
            compare("o_reprio", d[0], reprio);
            check_outputs();
        end

        // Fill from a random page
        clear_strobes();
        physpg_wr = 1'b1;
        y         = rand_bits(32);
        tick();
        start = m_pg;
        for (int p = 0; p < PAGES; p++)
            saved[p] = m_reprio[p];
        clear_strobes();
        fill_start = 1'b1;
        tick();
        compare("o_fill_busy", 1'b1, fill_busy);
        cycles = 0;
        while (fill_busy === 1'b1 && cycles < FILL_TIMEOUT) begin
            clear_strobes();
            reprio_wr  = 1'(rand_bits(1));              // Must be ignored
            d          = 3'(rand_bits(3));
            fill_start = 1'(rand_bits(1));
            physpg_wr  = 1'(rand_bits(1));
            y          = rand_bits(32);
            tick();
            check_outputs();
            cycles++;
        end
        if (fill_busy === 1'b1) begin
            timeouts++;
            $display("Fill still busy after %0d cycles, gave up waiting", cycles);
        end
        compare("fill_cycles", PAGES - start, cycles);
        for (int p = 0; p < PAGES; p++) begin
            clear_strobes();
            physpg_wr = 1'b1;
            y         = p << 10;
            tick();
            compare("o_reprio", (p >= start) ? 1'b1 : saved[p], reprio);
        end

        // Reset in the middle of a fill, from unpaged BESM-6 mode
        set_mode(1);
        set_mode(2);
        clear_strobes();
        set_besm6 = 1'b1;
        physpg_wr = 1'b1;
        y         = '0;
        tick();
        clear_strobes();
        fill_start = 1'b1;
        tick();
        clear_strobes();
        reset = 1'b1;
        repeat (4) tick();
        reset = 1'b0;
        compare("o_fill_busy", 1'b0, fill_busy);
        compare("o_rr", 32'h0, rr);
        compare("o_physad", {m_map[0][19:10], 10'd0}, physad);   // ureg 0, paged
        check_outputs();

        // Long virtual page again, upper five page bits set
        clear_strobes();
        ureg_wr = 1'b1;
        y       = rand_bits(32) | 32'h000f_8000;        // ureg 19:15 all ones
        tick();
        check_outputs();

        $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
